// ==== include/btb_macros.svh ====
// Geometry and PC field positions for the branch target buffer.
// Included by the package and by every RTL file that needs array sizes.
// The set index and slot are taken straight from the fetch PC.

`ifndef BTB_MACROS_SVH
`define BTB_MACROS_SVH

// Array geometry
`define BTB_SETS       512   // Number of sets, one line each
`define BTB_INDEX_W    9     // log2 of BTB_SETS
`define BTB_SLOTS      4     // Instruction slots per 16-byte fetch block
`define BTB_SLOT_W     2     // log2 of BTB_SLOTS
`define BTB_TARGET_W   32    // Width of one stored target
`define BTB_TARGETS_W  128   // All targets of one line
`define BTB_LINE_W     129   // Valid bit above four targets

// PC fields
`define BTB_PC_W       32    // Fetch and resolve PC width
`define BTB_INDEX_LSB  4     // Set index is PC[12:4]
`define BTB_SLOT_LSB   2     // Slot is PC[3:2]

// Performance counter width
`define BTB_COUNT_W    32

`endif

// ==== rtl/bpu_pkg.sv ====
// Shared types of the branch prediction front end.
// Referenced by scoped name from the update unit, the BTB and the top level.

`include "btb_macros.svh"

package bpu_pkg;

    ////////////////////////////////////////
    // BTB line layout
    ////////////////////////////////////////

    // Slot 0 sits in the lowest 32 bits, valid in bit 128
    typedef struct packed {
        logic                                      valid;
        logic [`BTB_SLOTS-1:0][`BTB_TARGET_W-1:0]  targets;
    } btb_line_t;

    ////////////////////////////////////////
    // Resolution opcodes
    ////////////////////////////////////////

    typedef enum logic {
        RESOLVE_SET   = 1'b0,   // Store target into slot
        RESOLVE_CLEAR = 1'b1    // Zero the slot
    } resolve_op_e;

    // Update unit FSM
    typedef enum logic [2:0] {
        UPD_CLEAR = 3'd0,       // Post-reset sweep of all sets
        UPD_IDLE  = 3'd1,       // Waiting for a resolution
        UPD_READ  = 3'd2,       // Old line read in flight
        UPD_MERGE = 3'd3,       // Old line back, build new one
        UPD_WRITE = 3'd4        // Merged line written
    } upd_state_e;

endpackage

// ==== rtl/btb_if.sv ====
// SRAM-style access bus used between the update unit, the lookup arbiter
// and the BTB storage. A cycle with ce high and we low is a read, with
// ce and we high it writes din at waddr. Read data returns one cycle later.

`timescale 1ns/1ps
`include "btb_macros.svh"

interface btb_if;

    // Request side
    logic                       ce;          // Access enable
    logic                       we;          // Write when set, read otherwise
    logic [`BTB_INDEX_W-1:0]    waddr;       // Write set index
    logic [`BTB_INDEX_W-1:0]    raddr;       // Read set index
    logic [`BTB_LINE_W-1:0]     din;         // Line to write

    // Response side
    logic                       rd_valid;    // Valid bit of last read line
    logic [`BTB_TARGETS_W-1:0]  rd_targets;  // Targets of last read line

    ////////////////////////////////////////
    // Modports
    ////////////////////////////////////////

    // Update unit issuing accesses
    modport requester (
        output ce, we, waddr, raddr, din,
        input  rd_valid, rd_targets
    );

    // Arbiter accepting accesses from the update unit
    modport arbiter (
        input  ce, we, waddr, raddr, din,
        output rd_valid, rd_targets
    );

    // Arbiter output towards storage
    modport ctrl (
        output ce, we, waddr, raddr, din,
        input  rd_valid, rd_targets
    );

    // Storage side
    modport mem (
        input  ce, we, waddr, raddr, din,
        output rd_valid, rd_targets
    );

endinterface

// ==== rtl/sram.sv ====
// Single-port style SRAM with separate read and write addresses and one
// enable. Reads register their data, which holds until the next read.
// Writes are bit-masked and only seen by reads in later cycles.

`timescale 1ns/1ps
`include "btb_macros.svh"

module sram (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     ce,       // Access enable
    input  logic                     we,       // Write when high
    input  logic [`BTB_INDEX_W-1:0]  waddr,
    input  logic [`BTB_INDEX_W-1:0]  raddr,
    input  logic [`BTB_LINE_W-1:0]   din,
    input  logic [`BTB_LINE_W-1:0]   wmask,    // Per-bit write enable
    output logic [`BTB_LINE_W-1:0]   dout      // Registered read data
);

    // Storage array, contents undefined until swept
    logic [`BTB_LINE_W-1:0] mem [`BTB_SETS];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (ce && we) begin
            // Keep unmasked bits of the old word
            mem[waddr] <= (mem[waddr] & ~wmask) | (din & wmask);
        end
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            dout <= '0;
        end else if (ce && !we) begin
            dout <= mem[raddr];  // Held until next read
        end
    end

endmodule

// ==== rtl/btb.sv ====
// Branch target buffer storage: 512 sets of one valid bit and four
// 32-bit targets, kept in one 129-bit wide SRAM. The read line is
// unpacked onto the bus, and returned reads of invalid sets are counted
// for the performance monitor.

`timescale 1ns/1ps
`include "btb_macros.svh"

module btb (
    input  logic                     clock,
    input  logic                     reset_n,
    btb_if.mem                       bus,
    output logic [`BTB_COUNT_W-1:0]  miss_count   // Reads that found an invalid set
);

    bpu_pkg::btb_line_t rd_line;    // Registered SRAM output
    logic               rd_pend;    // A read returns this cycle

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    sram u_sram (
        .clock   (clock),
        .reset_n (reset_n),
        .ce      (bus.ce),
        .we      (bus.we),
        .waddr   (bus.waddr),
        .raddr   (bus.raddr),
        .din     (bus.din),
        .wmask   ({`BTB_LINE_W{bus.we}}),   // Whole line on every write
        .dout    (rd_line)
    );

    // Unpack the line
    assign bus.rd_valid   = rd_line.valid;
    assign bus.rd_targets = rd_line.targets;

    ////////////////////////////////////////
    // Read miss counter
    ////////////////////////////////////////

    // Data shows up one cycle after the read, so remember the request
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= bus.ce && !bus.we;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            miss_count <= '0;
        end else if (rd_pend && !rd_line.valid) begin
            miss_count <= miss_count + 1'b1;   // Lookup and update reads alike
        end
    end

endmodule

// ==== rtl/btb_update_unit.sv ====
// BTB update unit. After reset it writes a zero line to every set, then
// serves branch resolutions with a read, merge and write of the set.
// Accepted at T, it reads at T+1, merges at T+2 and writes at T+3.
// All bus outputs are registered, so they are low right after reset.

`timescale 1ns/1ps
`include "btb_macros.svh"

module btb_update_unit (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      resolve_valid,
    input  bpu_pkg::resolve_op_e      resolve_op,
    input  logic [`BTB_PC_W-1:0]      resolve_pc,
    input  logic [`BTB_TARGET_W-1:0]  resolve_target,
    output logic                      resolve_ready,
    btb_if.requester                  bus
);

    bpu_pkg::upd_state_e        state;
    logic [`BTB_INDEX_W-1:0]    clr_cnt;     // Sweep position
    logic                       ce_q;
    logic                       we_q;
    logic [`BTB_INDEX_W-1:0]    addr_q;      // Captured set index or sweep address
    logic [`BTB_LINE_W-1:0]     din_q;
    logic [`BTB_SLOT_W-1:0]     slot_q;
    bpu_pkg::resolve_op_e       op_q;
    logic [`BTB_TARGET_W-1:0]   tgt_q;
    logic                       accept;
    bpu_pkg::btb_line_t         merged;

    // Ready only once the last sweep write has left the bus
    assign resolve_ready = (state == bpu_pkg::UPD_IDLE) && !ce_q;
    assign accept        = resolve_valid && resolve_ready;

    assign bus.ce    = ce_q;
    assign bus.we    = we_q;
    assign bus.waddr = addr_q;
    assign bus.raddr = addr_q;
    assign bus.din   = din_q;

    ////////////////////////////////////////
    // Merge of returned line
    ////////////////////////////////////////

    always_comb begin
        merged.valid   = 1'b0;
        merged.targets = '0;
        if (bus.rd_valid) begin
            merged.targets = bus.rd_targets;   // Invalid set reads as all zero
        end
        if (op_q == bpu_pkg::RESOLVE_SET) begin
            merged.targets[slot_q] = tgt_q;
            merged.valid           = 1'b1;
        end else begin
            merged.targets[slot_q] = '0;
            merged.valid           = |merged.targets;   // Any slot left
        end
    end

    ////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state   <= bpu_pkg::UPD_CLEAR;
            clr_cnt <= '0;
            ce_q    <= 1'b0;
            we_q    <= 1'b0;
        end else begin
            case (state)
                bpu_pkg::UPD_CLEAR: begin
                    ce_q    <= 1'b1;
                    we_q    <= 1'b1;
                    clr_cnt <= clr_cnt + 1'b1;
                    if (&clr_cnt) state <= bpu_pkg::UPD_IDLE;   // Set 511 issued
                end
                bpu_pkg::UPD_IDLE: begin
                    ce_q <= accept;         // Read old line next cycle
                    we_q <= 1'b0;
                    if (accept) state <= bpu_pkg::UPD_READ;
                end
                bpu_pkg::UPD_READ: begin
                    ce_q  <= 1'b0;
                    state <= bpu_pkg::UPD_MERGE;
                end
                bpu_pkg::UPD_MERGE: begin
                    ce_q  <= 1'b1;          // Write merged line
                    we_q  <= 1'b1;
                    state <= bpu_pkg::UPD_WRITE;
                end
                bpu_pkg::UPD_WRITE: begin
                    ce_q  <= 1'b0;
                    we_q  <= 1'b0;
                    state <= bpu_pkg::UPD_IDLE;
                end
                default: state <= bpu_pkg::UPD_IDLE;
            endcase
        end
    end

    // Address, line and captured resolution
    always_ff @(posedge clock) begin
        if (state == bpu_pkg::UPD_CLEAR) begin
            addr_q <= clr_cnt;
            din_q  <= '0;
        end else if (accept) begin
            addr_q <= resolve_pc[`BTB_INDEX_LSB +: `BTB_INDEX_W];
            slot_q <= resolve_pc[`BTB_SLOT_LSB +: `BTB_SLOT_W];
            op_q   <= resolve_op;
            tgt_q  <= resolve_target;
        end else if (state == bpu_pkg::UPD_MERGE) begin
            din_q  <= merged;
        end
    end

endmodule

// ==== rtl/btb_lookup.sv ====
// Fetch lookup and arbiter for the single BTB port. Update accesses win,
// fetch reads go out only when the update bus is quiet and the post-reset
// sweep is over. A fetch accepted at T gets its prediction at T+1, taken
// from the slot the PC names in the returned line.

`timescale 1ns/1ps
`include "btb_macros.svh"

module btb_lookup (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      fetch_valid,
    input  logic [`BTB_PC_W-1:0]      fetch_pc,
    output logic                      lookup_ready,
    output logic                      pred_valid,
    output logic                      pred_hit,
    output logic [`BTB_TARGET_W-1:0]  pred_target,
    btb_if.arbiter                    upd_bus,
    btb_if.ctrl                       mem_bus
);

    logic                       init_done;   // Sweep has written the last set
    logic                       fetch_go;    // Fetch accepted this cycle
    logic                       pend_q;      // Lookup data returns this cycle
    logic [`BTB_SLOT_W-1:0]     slot_q;      // Slot of the returning lookup
    logic [`BTB_TARGET_W-1:0]   slot_tgt;

    ////////////////////////////////////////
    // Sweep tracking
    ////////////////////////////////////////

    // Last set index is all ones for a power-of-two array
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            init_done <= 1'b0;
        end else if (upd_bus.ce && upd_bus.we && (&upd_bus.waddr)) begin
            init_done <= 1'b1;
        end
    end

    assign lookup_ready = init_done && !upd_bus.ce;   // Update has priority
    assign fetch_go     = fetch_valid && lookup_ready;

    ////////////////////////////////////////
    // Port arbitration
    ////////////////////////////////////////

    assign mem_bus.ce    = upd_bus.ce || fetch_go;
    assign mem_bus.we    = upd_bus.ce && upd_bus.we;   // Fetch only reads
    assign mem_bus.waddr = upd_bus.waddr;
    assign mem_bus.raddr = upd_bus.ce ? upd_bus.raddr
                                      : fetch_pc[`BTB_INDEX_LSB +: `BTB_INDEX_W];
    assign mem_bus.din   = upd_bus.din;

    // Read data goes back to the update unit unchanged
    assign upd_bus.rd_valid   = mem_bus.rd_valid;
    assign upd_bus.rd_targets = mem_bus.rd_targets;

    ////////////////////////////////////////
    // Request tracking
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= fetch_go;   // One prediction per accepted fetch
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_go) begin
            slot_q <= fetch_pc[`BTB_SLOT_LSB +: `BTB_SLOT_W];
        end
    end

    ////////////////////////////////////////
    // Prediction
    ////////////////////////////////////////

    assign slot_tgt = mem_bus.rd_targets[slot_q * `BTB_TARGET_W +: `BTB_TARGET_W];

    assign pred_valid  = pend_q;
    assign pred_hit    = pend_q && mem_bus.rd_valid && (|slot_tgt);   // Zero target is empty
    assign pred_target = pred_hit ? slot_tgt : '0;

endmodule

// ==== rtl/bpu_top.sv ====
// Top level of the BTB front end. Fetch and branch resolution come in on
// plain ports; the update unit and lookup share the BTB through the
// lookup's arbiter. miss_count is exported for the performance monitor.

`timescale 1ns/1ps
`include "btb_macros.svh"

module bpu_top (
    input  logic                      clock,
    input  logic                      reset_n,

    // Fetch
    input  logic                      fetch_valid,
    input  logic [`BTB_PC_W-1:0]      fetch_pc,
    output logic                      lookup_ready,
    output logic                      pred_valid,
    output logic                      pred_hit,
    output logic [`BTB_TARGET_W-1:0]  pred_target,

    // Branch resolution
    input  logic                      resolve_valid,
    input  bpu_pkg::resolve_op_e      resolve_op,
    input  logic [`BTB_PC_W-1:0]      resolve_pc,
    input  logic [`BTB_TARGET_W-1:0]  resolve_target,
    output logic                      resolve_ready,

    // PMU
    output logic [`BTB_COUNT_W-1:0]   miss_count
);

    btb_if upd_bus ();   // Update unit to arbiter
    btb_if mem_bus ();   // Arbiter to storage

    btb_update_unit u_update (
        .clock          (clock),
        .reset_n        (reset_n),
        .resolve_valid  (resolve_valid),
        .resolve_op     (resolve_op),
        .resolve_pc     (resolve_pc),
        .resolve_target (resolve_target),
        .resolve_ready  (resolve_ready),
        .bus            (upd_bus.requester)
    );

    btb_lookup u_lookup (
        .clock        (clock),
        .reset_n      (reset_n),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .lookup_ready (lookup_ready),
        .pred_valid   (pred_valid),
        .pred_hit     (pred_hit),
        .pred_target  (pred_target),
        .upd_bus      (upd_bus.arbiter),
        .mem_bus      (mem_bus.ctrl)
    );

    btb u_btb (
        .clock      (clock),
        .reset_n    (reset_n),
        .bus        (mem_bus.mem),
        .miss_count (miss_count)
    );

endmodule

// ==== tb/tb_bpu.sv ====
// Testbench for the BTB front end. Drives fetch and branch resolution
// traffic into bpu_top, keeps a model of the BTB array, checks each
// prediction against it and compares the miss counter at quiet points.

`timescale 1ns/1ps
`include "btb_macros.svh"

module tb_bpu;

    logic                       clock;
    logic                       reset_n;
    logic                       fetch_valid;
    logic [`BTB_PC_W-1:0]       fetch_pc;
    logic                       lookup_ready;
    logic                       pred_valid;
    logic                       pred_hit;
    logic [`BTB_TARGET_W-1:0]   pred_target;
    logic                       resolve_valid;
    bpu_pkg::resolve_op_e       resolve_op;
    logic [`BTB_PC_W-1:0]       resolve_pc;
    logic [`BTB_TARGET_W-1:0]   resolve_target;
    logic                       resolve_ready;
    logic [`BTB_COUNT_W-1:0]    miss_count;

    // Reference model of the array
    logic                       ref_valid [`BTB_SETS];
    logic [`BTB_TARGET_W-1:0]   ref_tgt   [`BTB_SETS][`BTB_SLOTS];
    int unsigned                ref_miss  = 0;    // Reads of invalid sets

    logic [64:0]                exp_q [$];        // {accept cycle, hit, target}
    int unsigned                cycle_cnt = 0;
    int unsigned                errors    = 0;
    int unsigned                checks    = 0;

    // Resolution in flight and its phase counted from the accept cycle
    int                         upd_phase = 0;
    bpu_pkg::resolve_op_e       upd_op;
    logic [`BTB_PC_W-1:0]       upd_pc;
    logic [`BTB_TARGET_W-1:0]   upd_tgt;

    bpu_top dut0 (
        .clock          (clock),
        .reset_n        (reset_n),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .lookup_ready   (lookup_ready),
        .pred_valid     (pred_valid),
        .pred_hit       (pred_hit),
        .pred_target    (pred_target),
        .resolve_valid  (resolve_valid),
        .resolve_op     (resolve_op),
        .resolve_pc     (resolve_pc),
        .resolve_target (resolve_target),
        .resolve_ready  (resolve_ready),
        .miss_count     (miss_count)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;          // 20 ns period

    always @(posedge clock) cycle_cnt <= cycle_cnt + 1;

    ////////////////////////////////////////
    // Reference functions
    ////////////////////////////////////////

    // Returns {hit, target} for the slot the PC names
    function automatic logic [32:0] predict_ref(input logic [`BTB_PC_W-1:0] pc);
        logic [`BTB_INDEX_W-1:0]    idx;
        logic [1:0]                 slot;
        logic [`BTB_TARGET_W-1:0]   tgt;
        idx  = pc[`BTB_INDEX_LSB +: `BTB_INDEX_W];
        slot = pc[`BTB_SLOT_LSB +: 2];
        tgt  = ref_tgt[idx][slot];
        if (ref_valid[idx] && tgt != 0) return {1'b1, tgt};
        return 33'd0;                   // Miss gives a zero target
    endfunction

    function automatic void apply_resolve_ref(input bpu_pkg::resolve_op_e op,
                                              input logic [`BTB_PC_W-1:0] pc,
                                              input logic [`BTB_TARGET_W-1:0] tgt);
        logic [`BTB_INDEX_W-1:0]    idx;
        logic [1:0]                 slot;
        logic                       any;
        int                         s;
        idx  = pc[`BTB_INDEX_LSB +: `BTB_INDEX_W];
        slot = pc[`BTB_SLOT_LSB +: 2];
        any  = 1'b0;
        if (!ref_valid[idx]) begin
            for (s = 0; s < `BTB_SLOTS; s++) begin
                ref_tgt[idx][s] = '0;   // Invalid line counts as empty
            end
        end
        if (op == bpu_pkg::RESOLVE_SET) begin
            ref_tgt[idx][slot] = tgt;
            ref_valid[idx]     = 1'b1;
        end else begin
            ref_tgt[idx][slot] = '0;
            for (s = 0; s < `BTB_SLOTS; s++) begin
                any = any | (ref_tgt[idx][s] != 0);
            end
            ref_valid[idx] = any;       // Valid only while a slot is left
        end
    endfunction

    ////////////////////////////////////////
    // Checking and reporting
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string msg);
        errors++;
        $display("ERROR t=%0t %s", $time, msg);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        $display("*** FAILED ***");
        $finish;
    endtask

    // Model side sampled mid-cycle where all signals are stable
    always @(negedge clock) begin
        logic [32:0] p;
        if (reset_n) begin
            if (upd_phase != 0) begin
                upd_phase++;
                if (upd_phase == 2 || upd_phase == 4) begin
                    check_value("lookup_ready", {31'd0, lookup_ready}, 32'd0);  // Read and write
                end
                check_value("resolve_ready", {31'd0, resolve_ready}, 32'd0);
                if (upd_phase == 4) begin
                    apply_resolve_ref(upd_op, upd_pc, upd_tgt);   // Write cycle T+3
                    upd_phase = 0;
                end
            end
            if (fetch_valid && lookup_ready) begin
                p = predict_ref(fetch_pc);
                if (!ref_valid[fetch_pc[`BTB_INDEX_LSB +: `BTB_INDEX_W]]) ref_miss++;
                exp_q.push_back({cycle_cnt, p});
            end
            if (resolve_valid && resolve_ready) begin
                if (!ref_valid[resolve_pc[`BTB_INDEX_LSB +: `BTB_INDEX_W]]) ref_miss++;
                upd_op    = resolve_op;
                upd_pc    = resolve_pc;
                upd_tgt   = resolve_target;
                upd_phase = 1;
            end
        end
    end

    // Compare each prediction pulse with the oldest expected result
    always @(negedge clock) begin
        logic [64:0] e;
        if (reset_n) begin
            if (pred_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR t=%0t prediction with no fetch outstanding", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_value("pred_cycle", cycle_cnt, e[64:33] + 1);
                    check_value("pred_hit", {31'd0, pred_hit}, {31'd0, e[32]});
                    check_value("pred_target", pred_target, e[31:0]);
                end
            end else if (exp_q.size() != 0 && exp_q[0][64:33] + 1 < cycle_cnt) begin
                errors++;
                $display("ERROR t=%0t no prediction for fetch of cycle %0d",
                         $time, exp_q[0][64:33]);
                e = exp_q.pop_front();
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////

    // Returns at mid-cycle of the accept cycle with the request still driven
    task automatic fetch_issue(input logic [`BTB_PC_W-1:0] pc);
        int wait_cnt;
        @(posedge clock);
        #1;
        fetch_valid = 1'b1;
        fetch_pc    = pc;
        wait_cnt    = 0;
        @(negedge clock);
        while (!lookup_ready) begin
            wait_cnt++;
            if (wait_cnt > 20) abort_run("fetch was not accepted in 20 cycles");
            @(negedge clock);
        end
    endtask

    task automatic fetch_stop();
        @(posedge clock);
        #1;
        fetch_valid = 1'b0;
    endtask

    task automatic resolve_issue(input bpu_pkg::resolve_op_e op,
                                 input logic [`BTB_PC_W-1:0] pc,
                                 input logic [`BTB_TARGET_W-1:0] tgt);
        int wait_cnt;
        @(posedge clock);
        #1;
        resolve_valid  = 1'b1;
        resolve_op     = op;
        resolve_pc     = pc;
        resolve_target = tgt;
        wait_cnt       = 0;
        @(negedge clock);
        while (!resolve_ready) begin
            wait_cnt++;
            if (wait_cnt > 20) abort_run("resolution was not accepted in 20 cycles");
            @(negedge clock);
        end
        @(posedge clock);
        #1;
        resolve_valid = 1'b0;           // One resolution per call
    endtask

    // Let traffic drain and compare the miss counter with the model
    task automatic settle_and_check();
        int wait_cnt;
        wait_cnt = 0;
        @(negedge clock);
        while (!resolve_ready || upd_phase != 0) begin
            wait_cnt++;
            if (wait_cnt > 20) abort_run("update unit did not return to idle");
            @(negedge clock);
        end
        repeat (3) @(negedge clock);
        check_value("miss_count", miss_count, ref_miss);
        if (exp_q.size() != 0) abort_run("fetches left without a prediction");
    endtask

    function automatic logic [31:0] rand_target();
        return ($urandom & 32'hffff_fffc) | 32'h10;   // Aligned and never zero
    endfunction

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        logic [`BTB_PC_W-1:0]   pc;
        logic [`BTB_PC_W-1:0]   base;
        logic [`BTB_COUNT_W-1:0] snap;
        int                     i;
        int                     j;
        int                     k;
        int                     wait_cnt;
        void'($urandom(32'h9e3b_6524));
        fetch_valid    = 1'b0;
        fetch_pc       = '0;
        resolve_valid  = 1'b0;
        resolve_op     = bpu_pkg::RESOLVE_SET;
        resolve_pc     = '0;
        resolve_target = '0;
        reset_n        = 1'b0;
        for (i = 0; i < `BTB_SETS; i++) begin
            ref_valid[i] = 1'b0;
            for (j = 0; j < `BTB_SLOTS; j++) ref_tgt[i][j] = '0;
        end

        // Outputs stay quiet during the four reset cycles
        repeat (3) @(posedge clock);
        @(negedge clock);
        check_value("pred_valid", {31'd0, pred_valid}, 32'd0);
        check_value("lookup_ready", {31'd0, lookup_ready}, 32'd0);
        check_value("resolve_ready", {31'd0, resolve_ready}, 32'd0);
        check_value("miss_count", miss_count, 32'd0);
        @(posedge clock);
        #1 reset_n = 1'b1;

        // 1. Clear sweep then all lookups miss
        wait_cnt = 0;
        @(negedge clock);
        while (!(lookup_ready && resolve_ready)) begin
            wait_cnt++;
            if (wait_cnt > 600) abort_run("ready did not rise after the clear sweep");
            @(negedge clock);
        end
        check_value("miss_count", miss_count, 32'd0);
        for (i = 0; i < 8; i++) fetch_issue($urandom & 32'hffff_fffc);
        fetch_stop();
        settle_and_check();

        // 2. Random targets and lookups of the same and nearby slots
        for (i = 0; i < 8; i++) begin
            pc = $urandom & 32'hffff_fffc;
            resolve_issue(bpu_pkg::RESOLVE_SET, pc, rand_target());
            fetch_issue(pc);
            fetch_issue(pc ^ 32'h4);
            fetch_issue(pc ^ 32'h8);
            fetch_issue(pc);
            fetch_stop();
        end
        settle_and_check();

        // 3. Fill one set and clear one slot before the rest
        base = $urandom & 32'hffff_fff0;
        for (i = 0; i < 4; i++) resolve_issue(bpu_pkg::RESOLVE_SET, base | (i << 2), rand_target());
        resolve_issue(bpu_pkg::RESOLVE_CLEAR, base | 32'h4, 32'd0);
        for (i = 0; i < 4; i++) fetch_issue(base | (i << 2));
        fetch_stop();
        resolve_issue(bpu_pkg::RESOLVE_CLEAR, base, 32'd0);
        resolve_issue(bpu_pkg::RESOLVE_CLEAR, base | 32'h8, 32'd0);
        resolve_issue(bpu_pkg::RESOLVE_CLEAR, base | 32'hc, 32'd0);
        for (i = 0; i < 4; i++) fetch_issue(base | (i << 2));
        fetch_stop();
        settle_and_check();
        snap = ref_miss;
        fetch_issue(base);              // Empty set must count as a miss
        fetch_stop();
        settle_and_check();
        check_value("miss_count_step", miss_count, snap + 1);

        // 4. Resolutions and fetches competing for the port
        base = $urandom & 32'hffff_fff0;
        fork
            begin
                for (j = 0; j < 4; j++) begin
                    resolve_issue(bpu_pkg::RESOLVE_SET, base | (j << 2), rand_target());
                end
                resolve_issue(bpu_pkg::RESOLVE_CLEAR, base | 32'h8, 32'd0);
            end
            begin
                for (k = 0; k < 24; k++) fetch_issue(base | ((k % 4) << 2));
                fetch_stop();
            end
        join
        settle_and_check();

        // 5. Final counter comparison
        settle_and_check();
        $display("Summary: %0d checks, %0d errors, %0d model misses",
                 checks, errors, ref_miss);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
rtl/bpu_pkg.sv
rtl/btb_if.sv
rtl/sram.sv
rtl/btb.sv
rtl/btb_update_unit.sv
rtl/btb_lookup.sv
rtl/bpu_top.sv
tb/tb_bpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the BTB front end testbench with Verilator and runs it.
# Exit status is 0 only when the run prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f tb.f --top-module tb_bpu -o sim_tb_bpu \
    || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/sim_tb_bpu)"
echo "$sim_out"

echo "$sim_out" | grep -qF '*** PASSED ***' \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
